/* idu.f */
+incdir+common
common/rv_isa_pkg.sv
common/idu_bus_pkg.sv
idu/idu_inst_buf.sv
idu/idu_ctrl_decode.sv
idu/idu_operand_gen.sv
idu/idu_issue.sv
idu/idu_top.sv
verif/tb_idu.sv

/* verif/tb_idu.sv */
// directed testbench for the idu decode stage with register and csr file models
`timescale 1ns/1ps
`default_nettype none

`include "idu_params.svh"

module tb_idu;

  localparam int TMO   = 40;
  localparam int STALL = 5;
  localparam int BURST = 6;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_REG    = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  logic                    clk;
  logic                    rst;
  logic                    in_valid;
  idu_bus_pkg::fetch_pkt_t in_pkt;
  logic                    in_ready;
  rv_isa_pkg::reg_idx_t    rs1_addr;
  rv_isa_pkg::reg_idx_t    rs2_addr;
  rv_isa_pkg::csr_idx_t    csr_addr;
  rv_isa_pkg::word_t       rs1_data;
  rv_isa_pkg::word_t       rs2_data;
  rv_isa_pkg::word_t       csr_data;
  idu_bus_pkg::busy_dest_t exu_busy;
  idu_bus_pkg::busy_dest_t lsu_busy;
  idu_bus_pkg::busy_dest_t wbu_busy;
  logic                    out_valid;
  idu_bus_pkg::dec_pkt_t   out_pkt;
  logic                    out_ready;

  idu_bus_pkg::dec_pkt_t   got;
  rv_isa_pkg::csr_idx_t    got_csr;
  rv_isa_pkg::reg_idx_t    got_rs1;
  rv_isa_pkg::reg_idx_t    got_rs2;
  int                      errors;
  int                      checks;

  idu_top i_idu_top (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_pkt    (in_pkt),
    .in_ready  (in_ready),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .csr_addr  (csr_addr),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .csr_data  (csr_data),
    .exu_busy  (exu_busy),
    .lsu_busy  (lsu_busy),
    .wbu_busy  (wbu_busy),
    .out_valid (out_valid),
    .out_pkt   (out_pkt),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // register file and csr file models
  assign rs1_data = 32'(rs1_addr) * 32'h0101_0101;
  assign rs2_data = 32'(rs2_addr) * 32'h0101_0101;
  assign csr_data = 32'h1000 + 32'(csr_addr) * 32'd16;

  function automatic rv_isa_pkg::word_t reg_val(rv_isa_pkg::reg_idx_t a);
    return 32'(a) * 32'h0101_0101;
  endfunction

  function automatic rv_isa_pkg::word_t enc_r(logic [6:0] f7, rv_isa_pkg::reg_idx_t rs2,
                                              rv_isa_pkg::reg_idx_t rs1, logic [2:0] f3,
                                              rv_isa_pkg::reg_idx_t rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic rv_isa_pkg::word_t enc_i(logic [11:0] imm, rv_isa_pkg::reg_idx_t rs1,
                                              logic [2:0] f3, rv_isa_pkg::reg_idx_t rd,
                                              logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_isa_pkg::word_t enc_s(logic [11:0] imm, rv_isa_pkg::reg_idx_t rs2,
                                              rv_isa_pkg::reg_idx_t rs1, logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic rv_isa_pkg::word_t enc_b(logic [12:0] imm, rv_isa_pkg::reg_idx_t rs2,
                                              rv_isa_pkg::reg_idx_t rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic rv_isa_pkg::word_t enc_u(logic [19:0] imm, rv_isa_pkg::reg_idx_t rd,
                                              logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic rv_isa_pkg::word_t enc_j(logic [20:0] imm, rv_isa_pkg::reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic check_val(input string name, input logic [31:0] val, input logic [31:0] exp);
    checks++;
    if (val !== exp) begin
      $display("FAILED %s got %h expected %h", name, val, exp);
      errors++;
    end
  endtask

  task automatic send_inst(input rv_isa_pkg::word_t inst, input rv_isa_pkg::word_t pc);
    int n;
    @(negedge clk);
    in_valid     = 1'b1;
    in_pkt.inst  = inst;
    in_pkt.pc    = pc;
    n = 0;
    while (!in_ready && n < TMO) begin
      @(negedge clk);
      n++;
    end
    if (!in_ready) begin
      $display("timeout: decode stage never accepted instruction %h", inst);
      errors++;
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic take_pkt();
    int n;
    n = 0;
    while (!out_valid && n < TMO) begin
      @(negedge clk);
      n++;
    end
    if (!out_valid) begin
      $display("timeout: no decode packet was offered");
      errors++;
    end
    got     = out_pkt;
    got_csr = csr_addr;
    got_rs1 = rs1_addr;
    got_rs2 = rs2_addr;
    out_ready = 1'b1;
    @(negedge clk);
    out_ready = 1'b0;
  endtask

  task automatic decode_one(input rv_isa_pkg::word_t inst, input rv_isa_pkg::word_t pc);
    send_inst(inst, pc);
    take_pkt();
  endtask

  task automatic test_reset();
    check_val("out_valid", out_valid, 32'd0);
    check_val("in_ready", in_ready, 32'd1);
    check_val("out_pkt.pc", out_pkt.pc, `IDU_RESET_PC);
  endtask

  task automatic test_immediates();
    rv_isa_pkg::word_t inst;
    // addi x1, x5, -5
    decode_one(enc_i(12'hffb, 5'd5, 3'b000, 5'd1, OPC_IMM), 32'h100);
    check_val("rs1_addr", got_rs1, 32'd5);
    check_val("imm", got.opnd.imm, 32'hffff_fffb);
    check_val("src1", got.opnd.src1, reg_val(5'd5));
    check_val("src2", got.opnd.src2, 32'hffff_fffb);
    inst = enc_u(20'habcde, 5'd2, OPC_LUI);
    decode_one(inst, 32'h104);
    check_val("imm", got.opnd.imm, 32'habcd_e000);
    check_val("src1", got.opnd.src1, reg_val(inst[19:15]));
    check_val("src2", got.opnd.src2, 32'habcd_e000);
    decode_one(enc_u(20'h12345, 5'd3, OPC_AUIPC), 32'h400);
    check_val("imm", got.opnd.imm, 32'h1234_5000);
    check_val("src1", got.opnd.src1, 32'h400);
    check_val("src2", got.opnd.src2, 32'h1234_5000);
    // sw x7, -8(x5)
    decode_one(enc_s(12'hff8, 5'd7, 5'd5, 3'b010), 32'h108);
    check_val("imm", got.opnd.imm, 32'hffff_fff8);
    check_val("src1", got.opnd.src1, reg_val(5'd5));
    check_val("src2", got.opnd.src2, 32'hffff_fff8);
    decode_one(enc_j(21'h000800, 5'd1), 32'h200);
    check_val("imm", got.opnd.imm, 32'h800);
    check_val("src1", got.opnd.src1, 32'h200);
    check_val("src2", got.opnd.src2, 32'h800);
    // beq x3, x7, -16
    decode_one(enc_b(13'h1ff0, 5'd7, 5'd3, 3'b000), 32'h300);
    check_val("rs2_addr", got_rs2, 32'd7);
    check_val("imm", got.opnd.imm, 32'hffff_fff0);
    check_val("src1", got.opnd.src1, reg_val(5'd3));
    check_val("src2", got.opnd.src2, reg_val(5'd7));
  endtask

  task automatic check_rtype(input logic [6:0] f7, input logic [2:0] f3,
                             input rv_isa_pkg::alu_op_e op);
    decode_one(enc_r(f7, 5'd2, 5'd1, f3, 5'd4, OPC_REG), 32'h0);
    check_val("alu_op", got.ctrl.alu_op, op);
    check_val("mem_read", got.ctrl.mem_read, 32'd0);
    check_val("mem_write", got.ctrl.mem_write, 32'd0);
    check_val("wd_sel", got.ctrl.wd_sel, rv_isa_pkg::WD_ALU);
    check_val("reg_write", got.ctrl.reg_write, 32'd1);
  endtask

  task automatic check_load(input logic [2:0] f3, input logic [1:0] size, input logic sgn);
    decode_one(enc_i(12'h010, 5'd2, f3, 5'd6, OPC_LOAD), 32'h0);
    check_val("alu_op", got.ctrl.alu_op, rv_isa_pkg::ALU_ADD);
    check_val("mem_read", got.ctrl.mem_read, 32'd1);
    check_val("mem_write", got.ctrl.mem_write, 32'd0);
    check_val("mem_size", got.ctrl.mem_size, size);
    check_val("mem_signed", got.ctrl.mem_signed, sgn);
    check_val("wd_sel", got.ctrl.wd_sel, rv_isa_pkg::WD_MEM);
    check_val("reg_write", got.ctrl.reg_write, 32'd1);
  endtask

  task automatic test_controls();
    check_rtype(7'h00, 3'd0, rv_isa_pkg::ALU_ADD);
    check_rtype(7'h00, 3'd1, rv_isa_pkg::ALU_SLL);
    check_rtype(7'h00, 3'd2, rv_isa_pkg::ALU_SLT);
    check_rtype(7'h00, 3'd3, rv_isa_pkg::ALU_SLTU);
    check_rtype(7'h00, 3'd4, rv_isa_pkg::ALU_XOR);
    check_rtype(7'h00, 3'd5, rv_isa_pkg::ALU_SRL);
    check_rtype(7'h00, 3'd6, rv_isa_pkg::ALU_OR);
    check_rtype(7'h00, 3'd7, rv_isa_pkg::ALU_AND);
    check_rtype(7'h20, 3'd0, rv_isa_pkg::ALU_SUB);
    check_rtype(7'h20, 3'd5, rv_isa_pkg::ALU_SRA);
    // mulhsu decodes as mulh
    check_rtype(7'h01, 3'd0, rv_isa_pkg::ALU_MUL);
    check_rtype(7'h01, 3'd1, rv_isa_pkg::ALU_MULH);
    check_rtype(7'h01, 3'd2, rv_isa_pkg::ALU_MULH);
    check_rtype(7'h01, 3'd3, rv_isa_pkg::ALU_MULHU);
    check_rtype(7'h01, 3'd4, rv_isa_pkg::ALU_DIV);
    check_rtype(7'h01, 3'd5, rv_isa_pkg::ALU_DIVU);
    check_rtype(7'h01, 3'd6, rv_isa_pkg::ALU_REM);
    check_rtype(7'h01, 3'd7, rv_isa_pkg::ALU_REMU);
    // lb lh lw lbu lhu
    check_load(3'b000, 2'd0, 1'b1);
    check_load(3'b001, 2'd1, 1'b1);
    check_load(3'b010, 2'd2, 1'b1);
    check_load(3'b100, 2'd0, 1'b0);
    check_load(3'b101, 2'd1, 1'b0);
    decode_one(enc_s(12'h004, 5'd3, 5'd2, 3'b010), 32'h0);
    check_val("mem_write", got.ctrl.mem_write, 32'd1);
    check_val("mem_read", got.ctrl.mem_read, 32'd0);
    check_val("mem_size", got.ctrl.mem_size, 32'd2);
    check_val("reg_write", got.ctrl.reg_write, 32'd0);
  endtask

  task automatic check_branch(input logic [2:0] f3, input rv_isa_pkg::reg_idx_t a,
                              input rv_isa_pkg::reg_idx_t b);
    rv_isa_pkg::word_t va;
    rv_isa_pkg::word_t vb;
    logic              taken;
    va = reg_val(a);
    vb = reg_val(b);
    case (f3)
      3'b000:  taken = (va == vb);
      3'b001:  taken = (va != vb);
      3'b100:  taken = ($signed(va) < $signed(vb));
      3'b101:  taken = ($signed(va) >= $signed(vb));
      3'b110:  taken = (va < vb);
      default: taken = (va >= vb);
    endcase
    decode_one(enc_b(13'h1ff0, b, a, f3), 32'h500);
    check_val("next_pc", got.opnd.next_pc, taken ? 32'h4f0 : 32'h504);
    check_val("redirect", got.opnd.redirect, taken);
  endtask

  task automatic test_next_pc();
    int f;
    for (f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        check_branch(f[2:0], 5'd5, 5'd5);
        check_branch(f[2:0], 5'd3, 5'd7);
        check_branch(f[2:0], 5'd7, 5'd3);
      end
    end
    decode_one(enc_j(21'h000040, 5'd1), 32'h600);
    check_val("next_pc", got.opnd.next_pc, 32'h640);
    check_val("redirect", got.opnd.redirect, 32'd1);
    // jalr x1, 2(x5) lands on an odd address
    decode_one(enc_i(12'h002, 5'd5, 3'b000, 5'd1, OPC_JALR), 32'h700);
    check_val("next_pc", got.opnd.next_pc, 32'h0505_0506);
    check_val("wd_sel", got.ctrl.wd_sel, rv_isa_pkg::WD_PC4);
  endtask

  task automatic check_csr(input logic [2:0] f3, input logic [11:0] addr, input logic [1:0] idx);
    decode_one(enc_i(addr, 5'd1, f3, 5'd5, OPC_SYSTEM), 32'h800);
    check_val("csr_addr", got_csr, idx);
    check_val("csr_rd", got.ctrl.csr_rd, idx);
    check_val("csr_write", got.ctrl.csr_write, 32'd1);
    check_val("wd_sel", got.ctrl.wd_sel, rv_isa_pkg::WD_CSR);
    check_val("reg_write", got.ctrl.reg_write, 32'd1);
    check_val("ebreak", got.ctrl.ebreak, 32'd0);
  endtask

  task automatic test_system();
    // ecall jumps to mtvec and saves the pc into mepc
    decode_one(32'h0000_0073, 32'h900);
    check_val("csr_addr", got_csr, 32'd3);
    check_val("next_pc", got.opnd.next_pc, 32'h1030);
    check_val("csr_write", got.ctrl.csr_write, 32'd1);
    check_val("csr_wd_pc", got.ctrl.csr_wd_pc, 32'd1);
    check_val("csr_rd", got.ctrl.csr_rd, 32'd1);
    check_val("ebreak", got.ctrl.ebreak, 32'd0);
    decode_one(32'h3020_0073, 32'h904);
    check_val("csr_addr", got_csr, 32'd1);
    check_val("next_pc", got.opnd.next_pc, 32'h1010);
    check_csr(3'b001, 12'h300, 2'd2);
    check_csr(3'b010, 12'h342, 2'd0);
    check_csr(3'b001, 12'h341, 2'd1);
    check_csr(3'b010, 12'h305, 2'd3);
    decode_one(32'h0010_0073, 32'h908);
    check_val("ebreak", got.ctrl.ebreak, 32'd1);
    check_val("csr_write", got.ctrl.csr_write, 32'd0);
  endtask

  task automatic hold_exu(input rv_isa_pkg::reg_idx_t rd);
    exu_busy           = '0;
    exu_busy.valid     = 1'b1;
    exu_busy.rd        = rd;
    exu_busy.reg_write = 1'b1;
  endtask

  task automatic test_hazard();
    int n;
    @(negedge clk);
    hold_exu(5'd7);
    // add x1, x3, x7 waits for x7
    send_inst(enc_r(7'h00, 5'd7, 5'd3, 3'b000, 5'd1, OPC_REG), 32'ha00);
    for (n = 0; n < STALL; n++) begin
      if (out_valid !== 1'b0) begin
        $display("add was offered while exu still writes x7");
        errors++;
      end
      @(negedge clk);
    end
    exu_busy = '0;
    take_pkt();
    check_val("pc", got.pc, 32'ha00);
    check_val("src2", got.opnd.src2, reg_val(5'd7));
    hold_exu(5'd0);
    send_inst(enc_r(7'h00, 5'd3, 5'd0, 3'b000, 5'd1, OPC_REG), 32'ha04);
    check_val("out_valid", out_valid, 32'd1);
    take_pkt();
    // rs2 field of addi holds immediate bits
    hold_exu(5'd7);
    send_inst(enc_i(12'h007, 5'd3, 3'b000, 5'd1, OPC_IMM), 32'ha08);
    check_val("out_valid", out_valid, 32'd1);
    take_pkt();
    exu_busy = '0;
  endtask

  task automatic test_backpressure();
    idu_bus_pkg::dec_pkt_t snap;
    int                    n;
    send_inst(enc_i(12'h011, 5'd2, 3'b000, 5'd3, OPC_IMM), 32'hb00);
    snap        = out_pkt;
    in_valid    = 1'b1;
    in_pkt.inst = enc_i(12'h022, 5'd2, 3'b000, 5'd3, OPC_IMM);
    in_pkt.pc   = 32'hb04;
    for (n = 0; n < 4; n++) begin
      @(negedge clk);
      check_val("in_ready", in_ready, 32'd0);
      if (out_pkt !== snap) begin
        $display("FAILED out_pkt got %h expected %h", out_pkt, snap);
        errors++;
      end
    end
    // second instruction refills as the first leaves
    take_pkt();
    in_valid = 1'b0;
    check_val("pc", got.pc, 32'hb00);
    take_pkt();
    check_val("pc", got.pc, 32'hb04);
    check_val("imm", got.opnd.imm, 32'h22);
  endtask

  task automatic drive_burst();
    int n;
    int i;
    for (i = 0; i < BURST; i++) begin
      @(negedge clk);
      in_valid    = 1'b1;
      in_pkt.inst = enc_i(12'(i), 5'd1, 3'b000, 5'd2, OPC_IMM);
      in_pkt.pc   = 32'hc00 + 32'(4 * i);
      n = 0;
      while (!in_ready && n < TMO) begin
        @(negedge clk);
        n++;
      end
      if (!in_ready) begin
        $display("timeout: burst instruction %0d was not accepted", i);
        errors++;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic watch_burst();
    int n;
    int i;
    n = 0;
    @(negedge clk);
    while (!out_valid && n < TMO) begin
      @(negedge clk);
      n++;
    end
    for (i = 0; i < BURST; i++) begin
      if (!out_valid) begin
        $display("bubble in front of burst instruction %0d", i);
        errors++;
      end
      check_val("pc", out_pkt.pc, 32'hc00 + 32'(4 * i));
      check_val("imm", out_pkt.opnd.imm, 32'(i));
      @(negedge clk);
    end
  endtask

  task automatic test_throughput();
    @(negedge clk);
    out_ready = 1'b1;
    fork
      drive_burst();
      watch_burst();
    join
    out_ready = 1'b0;
  endtask

  initial begin
    errors    = 0;
    checks    = 0;
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_pkt    = '0;
    out_ready = 1'b0;
    exu_busy  = '0;
    lsu_busy  = '0;
    wbu_busy  = '0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    test_reset();
    test_immediates();
    test_controls();
    test_next_pc();
    test_system();
    test_hazard();
    test_backpressure();
    test_throughput();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* idu/idu_top.sv */
// instruction decode stage of the rv32im pipeline
`timescale 1ns/1ps
`default_nettype none

module idu_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  input  idu_bus_pkg::fetch_pkt_t in_pkt,
  output logic                    in_ready,
  output rv_isa_pkg::reg_idx_t    rs1_addr,
  output rv_isa_pkg::reg_idx_t    rs2_addr,
  output rv_isa_pkg::csr_idx_t    csr_addr,
  input  rv_isa_pkg::word_t       rs1_data,
  input  rv_isa_pkg::word_t       rs2_data,
  input  rv_isa_pkg::word_t       csr_data,
  input  idu_bus_pkg::busy_dest_t exu_busy,
  input  idu_bus_pkg::busy_dest_t lsu_busy,
  input  idu_bus_pkg::busy_dest_t wbu_busy,
  output logic                    out_valid,
  output idu_bus_pkg::dec_pkt_t   out_pkt,
  input  logic                    out_ready
);

  idu_bus_pkg::fetch_pkt_t held_pkt;
  idu_bus_pkg::ctrl_t      ctrl;
  idu_bus_pkg::opnd_t      opnd;
  logic                    held_valid;
  logic                    consume;

  assign rs1_addr = held_pkt.inst[19:15];
  assign rs2_addr = held_pkt.inst[24:20];

  idu_inst_buf i_inst_buf (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_pkt     (in_pkt),
    .in_ready   (in_ready),
    .consume    (consume),
    .held_valid (held_valid),
    .held_pkt   (held_pkt)
  );

  idu_ctrl_decode i_ctrl_decode (
    .inst (held_pkt.inst),
    .ctrl (ctrl)
  );

  idu_operand_gen i_operand_gen (
    .pc       (held_pkt.pc),
    .inst     (held_pkt.inst),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .csr_data (csr_data),
    .csr_addr (csr_addr),
    .opnd     (opnd)
  );

  idu_issue i_issue (
    .held_valid (held_valid),
    .held_pkt   (held_pkt),
    .ctrl       (ctrl),
    .opnd       (opnd),
    .exu_busy   (exu_busy),
    .lsu_busy   (lsu_busy),
    .wbu_busy   (wbu_busy),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_pkt    (out_pkt),
    .consume    (consume)
  );

endmodule

`default_nettype wire

/* idu/idu_issue.sv */
// issue: hazard check against later stages and output handshake
`timescale 1ns/1ps
`default_nettype none

module idu_issue (
  input  logic                    held_valid,
  input  idu_bus_pkg::fetch_pkt_t held_pkt,
  input  idu_bus_pkg::ctrl_t      ctrl,
  input  idu_bus_pkg::opnd_t      opnd,
  input  idu_bus_pkg::busy_dest_t exu_busy,
  input  idu_bus_pkg::busy_dest_t lsu_busy,
  input  idu_bus_pkg::busy_dest_t wbu_busy,
  output logic                    out_valid,
  input  logic                    out_ready,
  output idu_bus_pkg::dec_pkt_t   out_pkt,
  output logic                    consume
);

  rv_isa_pkg::reg_idx_t rs1;
  rv_isa_pkg::reg_idx_t rs2;
  rv_isa_pkg::csr_idx_t csr_src;
  logic                 use_rs1;
  logic                 use_rs2;
  logic                 use_csr;
  logic                 hazard;

  function automatic logic stage_hit(idu_bus_pkg::busy_dest_t b, rv_isa_pkg::reg_idx_t r1,
                                     rv_isa_pkg::reg_idx_t r2, logic u1, logic u2,
                                     logic uc, rv_isa_pkg::csr_idx_t cs);
    logic reg_hit;
    logic csr_hit;
    reg_hit = b.reg_write && (b.rd != 5'd0) && ((u1 && b.rd == r1) || (u2 && b.rd == r2));
    csr_hit = b.csr_write && uc && (b.csr_rd == cs);
    return b.valid && (reg_hit || csr_hit);
  endfunction

  assign rs1     = held_pkt.inst[19:15];
  assign rs2     = held_pkt.inst[24:20];
  assign csr_src = rv_isa_pkg::csr_src_idx(held_pkt.inst);

  // which sources the format reads
  assign use_rs1 = !(ctrl.fmt == rv_isa_pkg::FMT_U || ctrl.fmt == rv_isa_pkg::FMT_J);
  assign use_rs2 = (ctrl.fmt == rv_isa_pkg::FMT_R) || (ctrl.fmt == rv_isa_pkg::FMT_S) ||
                   (ctrl.fmt == rv_isa_pkg::FMT_B);
  assign use_csr = (ctrl.fmt == rv_isa_pkg::FMT_SYS);

  assign hazard = stage_hit(exu_busy, rs1, rs2, use_rs1, use_rs2, use_csr, csr_src) ||
                  stage_hit(lsu_busy, rs1, rs2, use_rs1, use_rs2, use_csr, csr_src) ||
                  stage_hit(wbu_busy, rs1, rs2, use_rs1, use_rs2, use_csr, csr_src);

  assign out_valid = held_valid && !hazard;
  assign consume   = out_valid && out_ready;

  assign out_pkt.pc   = held_pkt.pc;
  assign out_pkt.ctrl = ctrl;
  assign out_pkt.opnd = opnd;

endmodule

`default_nettype wire

/* idu/idu_operand_gen.sv */
// operand generator: immediate, alu sources, branch resolve and next pc
`timescale 1ns/1ps
`default_nettype none

module idu_operand_gen (
  input  rv_isa_pkg::word_t    pc,
  input  rv_isa_pkg::word_t    inst,
  input  rv_isa_pkg::word_t    rs1_data,
  input  rv_isa_pkg::word_t    rs2_data,
  input  rv_isa_pkg::word_t    csr_data,
  output rv_isa_pkg::csr_idx_t csr_addr,
  output idu_bus_pkg::opnd_t   opnd
);

  rv_isa_pkg::opcode_e opcode;
  rv_isa_pkg::fmt_e    fmt;
  rv_isa_pkg::word_t   imm;
  rv_isa_pkg::word_t   pc_plus4;
  logic [2:0]          funct3;
  logic                is_eq;
  logic                is_lt;
  logic                is_ltu;
  logic                taken;
  logic                is_trap;

  assign opcode   = rv_isa_pkg::opcode_e'(inst[6:0]);
  assign fmt      = rv_isa_pkg::inst_fmt(inst[6:0]);
  assign funct3   = inst[14:12];
  assign pc_plus4 = pc + 32'd4;
  assign csr_addr = rv_isa_pkg::csr_src_idx(inst);
  assign is_trap  = (inst == rv_isa_pkg::INST_ECALL) || (inst == rv_isa_pkg::INST_MRET);

  always_comb begin
    case (fmt)
      rv_isa_pkg::FMT_I:   imm = {{20{inst[31]}}, inst[31:20]};
      rv_isa_pkg::FMT_U:   imm = {inst[31:12], 12'h000};
      rv_isa_pkg::FMT_S:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      rv_isa_pkg::FMT_J:   imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      rv_isa_pkg::FMT_B:   imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      // zero extended csr address
      rv_isa_pkg::FMT_SYS: imm = {20'h00000, inst[31:20]};
      default:             imm = '0;
    endcase
  end

  assign is_eq  = (rs1_data == rs2_data);
  assign is_lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign is_ltu = (rs1_data < rs2_data);

  always_comb begin
    case (funct3)
      3'b000:  taken = is_eq;
      3'b001:  taken = !is_eq;
      3'b100:  taken = is_lt;
      3'b101:  taken = !is_lt;
      3'b110:  taken = is_ltu;
      3'b111:  taken = !is_ltu;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    opnd.imm  = imm;
    opnd.src1 = (opcode == rv_isa_pkg::OP_AUIPC || opcode == rv_isa_pkg::OP_JAL) ? pc : rs1_data;
    case (fmt)
      rv_isa_pkg::FMT_R, rv_isa_pkg::FMT_B: opnd.src2 = rs2_data;
      rv_isa_pkg::FMT_SYS:                  opnd.src2 = csr_data;
      default:                              opnd.src2 = imm;
    endcase

    opnd.next_pc = pc_plus4;
    if (is_trap) begin
      // mtvec for ecall, mepc for mret
      opnd.next_pc = csr_data;
    end else if (opcode == rv_isa_pkg::OP_JALR) begin
      opnd.next_pc = (rs1_data + imm) & ~32'd1;
    end else if (opcode == rv_isa_pkg::OP_JAL || (opcode == rv_isa_pkg::OP_BRANCH && taken)) begin
      opnd.next_pc = pc + imm;
    end
    opnd.redirect = (opnd.next_pc != pc_plus4);
  end

endmodule

`default_nettype wire

/* idu/idu_ctrl_decode.sv */
// control decoder: alu operation, memory and write-back controls
`timescale 1ns/1ps
`default_nettype none

module idu_ctrl_decode (
  input  rv_isa_pkg::word_t  inst,
  output idu_bus_pkg::ctrl_t ctrl
);

  rv_isa_pkg::opcode_e opcode;
  rv_isa_pkg::alu_op_e alu_base;
  rv_isa_pkg::alu_op_e alu_mext;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic                is_ecall;
  logic                is_csr_op;

  assign opcode    = rv_isa_pkg::opcode_e'(inst[6:0]);
  assign funct3    = inst[14:12];
  assign funct7    = inst[31:25];
  assign is_ecall  = (inst == rv_isa_pkg::INST_ECALL);
  assign is_csr_op = (opcode == rv_isa_pkg::OP_SYSTEM) &&
                     (funct3 == 3'b001 || funct3 == 3'b010);

  // common to op-imm and op
  always_comb begin
    case (funct3)
      3'b000:  alu_base = rv_isa_pkg::ALU_ADD;
      3'b001:  alu_base = rv_isa_pkg::ALU_SLL;
      3'b010:  alu_base = rv_isa_pkg::ALU_SLT;
      3'b011:  alu_base = rv_isa_pkg::ALU_SLTU;
      3'b100:  alu_base = rv_isa_pkg::ALU_XOR;
      3'b101:  alu_base = funct7[5] ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
      3'b110:  alu_base = rv_isa_pkg::ALU_OR;
      default: alu_base = rv_isa_pkg::ALU_AND;
    endcase
  end

  // mulhsu has no code of its own and shares mulh
  always_comb begin
    case (funct3)
      3'b000:  alu_mext = rv_isa_pkg::ALU_MUL;
      3'b001:  alu_mext = rv_isa_pkg::ALU_MULH;
      3'b010:  alu_mext = rv_isa_pkg::ALU_MULH;
      3'b011:  alu_mext = rv_isa_pkg::ALU_MULHU;
      3'b100:  alu_mext = rv_isa_pkg::ALU_DIV;
      3'b101:  alu_mext = rv_isa_pkg::ALU_DIVU;
      3'b110:  alu_mext = rv_isa_pkg::ALU_REM;
      default: alu_mext = rv_isa_pkg::ALU_REMU;
    endcase
  end

  always_comb begin
    ctrl           = '0;
    ctrl.fmt       = rv_isa_pkg::inst_fmt(inst[6:0]);
    ctrl.alu_op    = rv_isa_pkg::ALU_ADD;
    ctrl.wd_sel    = rv_isa_pkg::WD_ALU;
    ctrl.reg_write = 1'b1;
    ctrl.rd        = inst[11:7];
    ctrl.csr_rd    = is_ecall ? rv_isa_pkg::CSR_MEPC : rv_isa_pkg::csr_index(inst[31:20]);
    ctrl.csr_write = is_csr_op || is_ecall;
    ctrl.csr_wd_pc = is_ecall;
    ctrl.ebreak    = (inst == rv_isa_pkg::INST_EBREAK);
    case (opcode)
      rv_isa_pkg::OP_LUI: ctrl.alu_op = rv_isa_pkg::ALU_PASS_IMM;
      rv_isa_pkg::OP_IMM: ctrl.alu_op = alu_base;
      rv_isa_pkg::OP_REG: begin
        if (funct7 == 7'b0000001) begin
          ctrl.alu_op = alu_mext;
        end else if (funct3 == 3'b000 && funct7[5]) begin
          ctrl.alu_op = rv_isa_pkg::ALU_SUB;
        end else begin
          ctrl.alu_op = alu_base;
        end
      end
      rv_isa_pkg::OP_LOAD: begin
        ctrl.mem_read   = 1'b1;
        ctrl.mem_size   = funct3[1:0];
        ctrl.mem_signed = !funct3[2];
        ctrl.wd_sel     = rv_isa_pkg::WD_MEM;
      end
      rv_isa_pkg::OP_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.mem_size  = funct3[1:0];
        ctrl.reg_write = 1'b0;
      end
      rv_isa_pkg::OP_BRANCH: begin
        ctrl.reg_write = 1'b0;
        ctrl.alu_op    = funct3[2] ? (funct3[1] ? rv_isa_pkg::ALU_SLTU : rv_isa_pkg::ALU_SLT)
                                   : rv_isa_pkg::ALU_SUB;
      end
      rv_isa_pkg::OP_JAL, rv_isa_pkg::OP_JALR: ctrl.wd_sel = rv_isa_pkg::WD_PC4;
      rv_isa_pkg::OP_SYSTEM: begin
        ctrl.reg_write = is_csr_op;
        ctrl.wd_sel    = is_csr_op ? rv_isa_pkg::WD_CSR : rv_isa_pkg::WD_ALU;
        // csrrs sets bits of the old value
        ctrl.alu_op    = funct3[1] ? rv_isa_pkg::ALU_OR : rv_isa_pkg::ALU_PASS_SRC2;
      end
      default: ctrl.alu_op = rv_isa_pkg::ALU_ADD;
    endcase
  end

endmodule

`default_nettype wire

/* idu/idu_inst_buf.sv */
// one-entry buffer holding the fetched instruction under decode
`timescale 1ns/1ps
`default_nettype none

`include "idu_params.svh"

module idu_inst_buf (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  input  idu_bus_pkg::fetch_pkt_t in_pkt,
  output logic                    in_ready,
  input  logic                    consume,
  output logic                    held_valid,
  output idu_bus_pkg::fetch_pkt_t held_pkt
);

  typedef enum logic {BUF_EMPTY, BUF_FULL} buf_state_e;

  buf_state_e state;
  logic       load;

  // refill while the current entry leaves
  assign in_ready   = (state == BUF_EMPTY) || consume;
  assign load       = in_valid && in_ready;
  assign held_valid = (state == BUF_FULL);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= BUF_EMPTY;
    end else begin
      case (state)
        BUF_EMPTY: if (load) state <= BUF_FULL;
        BUF_FULL:  if (consume && !load) state <= BUF_EMPTY;
        default:   state <= BUF_EMPTY;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      held_pkt.inst <= `IDU_NOP_INST;
      held_pkt.pc   <= `IDU_RESET_PC;
    end else if (load) begin
      held_pkt <= in_pkt;
    end
  end

endmodule

`default_nettype wire

/* common/idu_bus_pkg.sv */
// pipeline packets between fetch, decode and the later stages
`default_nettype none

`include "idu_params.svh"

package idu_bus_pkg;

  typedef struct packed {
    logic [`IDU_ILEN-1:0] inst;
    rv_isa_pkg::word_t    pc;
  } fetch_pkt_t;

  // pending write of a later stage
  typedef struct packed {
    logic                 valid;
    rv_isa_pkg::reg_idx_t rd;
    logic                 reg_write;
    rv_isa_pkg::csr_idx_t csr_rd;
    logic                 csr_write;
  } busy_dest_t;

  typedef struct packed {
    rv_isa_pkg::fmt_e     fmt;
    rv_isa_pkg::alu_op_e  alu_op;
    rv_isa_pkg::wd_sel_e  wd_sel;
    logic                 reg_write;
    logic                 csr_write;
    logic                 csr_wd_pc;
    logic                 mem_read;
    logic                 mem_write;
    logic [1:0]           mem_size;
    logic                 mem_signed;
    logic                 ebreak;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::csr_idx_t csr_rd;
  } ctrl_t;

  typedef struct packed {
    rv_isa_pkg::word_t imm;
    rv_isa_pkg::word_t src1;
    rv_isa_pkg::word_t src2;
    rv_isa_pkg::word_t next_pc;
    logic              redirect;
  } opnd_t;

  typedef struct packed {
    rv_isa_pkg::word_t pc;
    ctrl_t             ctrl;
    opnd_t             opnd;
  } dec_pkt_t;

endpackage

`default_nettype wire

/* common/rv_isa_pkg.sv */
// rv32im isa types: opcodes, formats, alu operations and csr indices
`default_nettype none

`include "idu_params.svh"

package rv_isa_pkg;

  typedef logic [`IDU_XLEN-1:0] word_t;
  typedef logic [4:0]           reg_idx_t;
  typedef logic [1:0]           csr_idx_t;

  localparam csr_idx_t CSR_MCAUSE  = 2'd0;
  localparam csr_idx_t CSR_MEPC    = 2'd1;
  localparam csr_idx_t CSR_MSTATUS = 2'd2;
  localparam csr_idx_t CSR_MTVEC   = 2'd3;

  localparam word_t INST_ECALL  = 32'h0000_0073;
  localparam word_t INST_EBREAK = 32'h0010_0073;
  localparam word_t INST_MRET   = 32'h3020_0073;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    FMT_I, FMT_U, FMT_S, FMT_J, FMT_B, FMT_R, FMT_SYS
  } fmt_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_PASS_IMM, ALU_PASS_SRC2,
    ALU_MUL, ALU_MULH, ALU_MULHU, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
  } alu_op_e;

  typedef enum logic [1:0] {
    WD_ALU, WD_MEM, WD_PC4, WD_CSR
  } wd_sel_e;

  function automatic fmt_e inst_fmt(logic [6:0] opc);
    case (opcode_e'(opc))
      OP_LUI, OP_AUIPC: return FMT_U;
      OP_JAL:           return FMT_J;
      OP_STORE:         return FMT_S;
      OP_BRANCH:        return FMT_B;
      OP_REG:           return FMT_R;
      OP_SYSTEM:        return FMT_SYS;
      default:          return FMT_I;
    endcase
  endfunction

  // unknown addresses fall back to mtvec
  function automatic csr_idx_t csr_index(logic [11:0] addr);
    case (addr)
      12'h342: return CSR_MCAUSE;
      12'h341: return CSR_MEPC;
      12'h300: return CSR_MSTATUS;
      12'h305: return CSR_MTVEC;
      default: return CSR_MTVEC;
    endcase
  endfunction

  // trap entry and return read fixed csrs
  function automatic csr_idx_t csr_src_idx(word_t inst);
    if (inst == INST_ECALL) return CSR_MTVEC;
    if (inst == INST_MRET) return CSR_MEPC;
    return csr_index(inst[31:20]);
  endfunction

endpackage

`default_nettype wire

/* common/idu_params.svh */
// decode stage widths and reset constants
`ifndef IDU_PARAMS_SVH
`define IDU_PARAMS_SVH

`define IDU_XLEN 32
`define IDU_ILEN 32

// state after reset
`define IDU_RESET_PC 32'h0000_0000
`define IDU_NOP_INST 32'h0000_0013

`endif
